// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = conv_layer_tb
FILELIST = conv_layer.f
LOG      = sim.log

.PHONY: sim clean

# build, run from the project root so the ROM file is found, then search the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: conv_layer.f
rtl/conv_pkg.sv
rtl/conv_weight_rom.sv
rtl/conv_sequencer.sv
rtl/conv_node.sv
rtl/conv_layer.sv
testbench/conv_layer_checker.sv
testbench/conv_layer_tb.sv

// File: conv_weights.mem
// taps w00 w01 w10 w11 w20 w21 in row-major order, then the bias; Q8.8 hex
0180
FF40
0040
FE00
0100
00C0
0020

// File: rtl/conv_layer.sv
`timescale 1ns/1ns
`default_nettype none

module conv_layer (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                start_i,
    input  conv_pkg::data_in_t  data_i,
    output logic                done_o,
    output conv_pkg::data_out_t data_o
);

    logic [conv_pkg::ADDR_W-1:0] rom_addr;
    conv_pkg::word_t             rom_data;
    conv_pkg::conv_step_t        step;

    conv_sequencer u_sequencer (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .start_i    (start_i),
        .rom_addr_o (rom_addr),
        .step_o     (step),
        .done_o     (done_o)
    );

    conv_weight_rom u_rom (
        .clk_i  (clk_i),
        .addr_i (rom_addr),
        .data_o (rom_data)
    );

    // one node per output row with shared step and weight
    for (genvar i = 0; i < conv_pkg::NUM_OUTPUTS; i++) begin : g_node
        conv_node #(
            .ROW_INDEX (i)
        ) u_node (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .step_i   (step),
            .weight_i (rom_data),
            .data_i   (data_i),
            .result_o (data_o[i])
        );
    end

endmodule

`default_nettype wire

// File: rtl/conv_node.sv
`timescale 1ns/1ns
`default_nettype none

module conv_node #(
    parameter int ROW_INDEX = 0
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  conv_pkg::conv_step_t step_i,
    input  conv_pkg::word_t      weight_i,
    input  conv_pkg::data_in_t   data_i,
    output conv_pkg::word_t      result_o
);

    logic [conv_pkg::ROW_IDX_W:0]            row_base;
    logic [conv_pkg::ROW_IDX_W:0]            sel_row;
    conv_pkg::word_t                         sel_word;
    logic signed [2*conv_pkg::WORD_SIZE-1:0] product;
    logic signed [conv_pkg::ACC_W-1:0]       shifted;
    logic signed [conv_pkg::ACC_W-1:0]       sum;
    logic signed [conv_pkg::ACC_W-1:0]       acc_q;
    logic                                    tap_step;

    assign tap_step = step_i.valid && !step_i.bias;

    // kernel row r of this output covers input row ROW_INDEX + r
    assign row_base = ROW_INDEX[conv_pkg::ROW_IDX_W:0];
    assign sel_row  = row_base
                    + {{(conv_pkg::ROW_IDX_W + 1 - conv_pkg::ROW_W){1'b0}}, step_i.row};
    assign sel_word = data_i[sel_row[conv_pkg::ROW_IDX_W-1:0]][step_i.col];

    // full precision product shifted back to the fixed-point scale
    // signed operands sign-extend to the accumulator width
    assign product = sel_word * weight_i;
    assign shifted = product >>> conv_pkg::FRAC_BITS;

    // on the bias step weight_i carries the bias
    assign sum = acc_q + weight_i;

    always_ff @(posedge clk_i) begin
        if (tap_step) begin
            if (step_i.first)
                acc_q <= shifted;
            else
                acc_q <= acc_q + shifted;
        end
    end

    // wraps to the word size without saturation
    always_ff @(posedge clk_i) begin
        if (reset_i)
            result_o <= '0;
        else if (step_i.valid && step_i.bias)
            result_o <= sum[conv_pkg::WORD_SIZE-1:0];
    end

    // sequencer row plus node offset stays inside the window
    assert property (@(posedge clk_i) disable iff (reset_i)
                     tap_step |-> sel_row < conv_pkg::INPUT_HEIGHT)
        else $error("node %0d selected row %0d", ROW_INDEX, sel_row);

endmodule

`default_nettype wire

// File: rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // window and kernel geometry
    localparam int INPUT_HEIGHT  = 4;
    localparam int KERNEL_HEIGHT = 3;
    localparam int KERNEL_WIDTH  = 2;
    localparam int WORD_SIZE     = 16;
    localparam int FRAC_BITS     = 8;

    localparam int NUM_TAPS    = KERNEL_HEIGHT * KERNEL_WIDTH;
    localparam int NUM_OUTPUTS = INPUT_HEIGHT - KERNEL_HEIGHT + 1;

    // bias lives right after the last tap
    localparam int ROM_DEPTH = NUM_TAPS + 1;
    localparam int ADDR_W    = $clog2(ROM_DEPTH);
    localparam int ACC_W     = 2 * WORD_SIZE + 4;

    localparam int ROW_W     = $clog2(KERNEL_HEIGHT);
    localparam int COL_W     = $clog2(KERNEL_WIDTH);
    localparam int ROW_IDX_W = $clog2(INPUT_HEIGHT);

    localparam logic [ADDR_W-1:0] BIAS_ADDR = ADDR_W'(NUM_TAPS);
    localparam logic [COL_W-1:0]  COL_LAST  = COL_W'(KERNEL_WIDTH - 1);

    typedef logic signed [WORD_SIZE-1:0] word_t;
    typedef word_t [INPUT_HEIGHT-1:0][KERNEL_WIDTH-1:0] data_in_t;
    typedef word_t [NUM_OUTPUTS-1:0] data_out_t;

    typedef enum logic {
        ST_DONE = 1'b0,
        ST_BUSY = 1'b1
    } conv_state_e;

    // work for one ROM word lined up with the ROM output
    typedef struct packed {
        logic             valid;
        logic             first;
        logic             bias;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } conv_step_t;

endpackage

`default_nettype wire

// File: rtl/conv_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module conv_sequencer (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        start_i,
    output logic [conv_pkg::ADDR_W-1:0] rom_addr_o,
    output conv_pkg::conv_step_t        step_o,
    output logic                        done_o
);

    conv_pkg::conv_state_e       state_q;
    conv_pkg::conv_state_e       state_d;
    logic [conv_pkg::ADDR_W-1:0] tap_q;
    logic [conv_pkg::ROW_W-1:0]  row_q;
    logic [conv_pkg::COL_W-1:0]  col_q;
    logic                        issue;
    conv_pkg::conv_step_t        step_d;

    // taps first and then the bias word, one address per cycle
    assign issue = (state_q == conv_pkg::ST_BUSY) && (tap_q <= conv_pkg::BIAS_ADDR);
    assign rom_addr_o = issue ? tap_q : '0;

    always_comb begin
        state_d = state_q;
        case (state_q)
            conv_pkg::ST_DONE: begin
                if (start_i)
                    state_d = conv_pkg::ST_BUSY;
            end
            conv_pkg::ST_BUSY: begin
                // leave once the bias word reaches the nodes
                if (step_o.bias)
                    state_d = conv_pkg::ST_DONE;
            end
            default: state_d = conv_pkg::ST_DONE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i)
            state_q <= conv_pkg::ST_DONE;
        else
            state_q <= state_d;
    end

    // tap counter whose column wraps into the row
    always_ff @(posedge clk_i) begin
        if (reset_i || state_q == conv_pkg::ST_DONE) begin
            tap_q <= '0;
            row_q <= '0;
            col_q <= '0;
        end else if (issue) begin
            tap_q <= tap_q + 1'b1;
            if (col_q == conv_pkg::COL_LAST) begin
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_comb begin
        step_d.valid = issue;
        step_d.first = issue && (tap_q == '0);
        step_d.bias  = issue && (tap_q == conv_pkg::BIAS_ADDR);
        step_d.row   = row_q;
        step_d.col   = col_q;
    end

    // delayed by one cycle to meet the ROM data
    always_ff @(posedge clk_i) begin
        if (reset_i)
            step_o <= '0;
        else
            step_o <= step_d;
    end

    assign done_o = (state_q == conv_pkg::ST_DONE);

    // nodes only see work while the layer is busy
    assert property (@(posedge clk_i) disable iff (reset_i) step_o.valid |-> !done_o)
        else $error("step issued while done");

    // bias step finishes the run on the next edge
    assert property (@(posedge clk_i) disable iff (reset_i) step_o.bias |=> done_o)
        else $error("done not raised after bias step");

endmodule

`default_nettype wire

// File: rtl/conv_weight_rom.sv
`timescale 1ns/1ns
`default_nettype none

module conv_weight_rom (
    input  logic                        clk_i,
    input  logic [conv_pkg::ADDR_W-1:0] addr_i,
    output conv_pkg::word_t             data_o
);

    // taps in row-major order, bias in the last entry
    conv_pkg::word_t mem [conv_pkg::ROM_DEPTH];

    initial begin
        $readmemh("conv_weights.mem", mem);
    end

    // one cycle read latency
    always_ff @(posedge clk_i) begin
        data_o <= mem[addr_i];
    end

    // sequencer never points past the bias word
    assert property (@(posedge clk_i) addr_i < conv_pkg::ROM_DEPTH)
        else $error("weight ROM address %0d out of range", addr_i);

endmodule

`default_nettype wire

// File: testbench/conv_layer_checker.sv
`timescale 1ns/1ns
`default_nettype none

module conv_layer_checker (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                start_i,
    input  conv_pkg::data_in_t  data_i,
    input  logic                done_i,
    input  conv_pkg::data_out_t data_out_i,
    output int                  value_errors_o,
    output int                  timing_errors_o,
    output int                  results_o
);

    conv_pkg::word_t     rom_image [conv_pkg::ROM_DEPTH];
    conv_pkg::data_out_t expected;
    conv_pkg::data_out_t held;
    logic                busy;
    int                  age;

    initial begin
        $readmemh("conv_weights.mem", rom_image);
        value_errors_o  = 0;
        timing_errors_o = 0;
        results_o       = 0;
        busy = 1'b0;
        age  = 0;
        held = '0;
    end

    // sum of shifted products plus bias wrapped to the word size
    function automatic conv_pkg::data_out_t conv_ref(input conv_pkg::data_in_t window);
        conv_pkg::data_out_t result;
        conv_pkg::word_t     pix;
        conv_pkg::word_t     wgt;
        longint              acc;
        longint              prod;
        int                  o;
        int                  r;
        int                  c;
        for (o = 0; o < conv_pkg::NUM_OUTPUTS; o++) begin
            acc = 0;
            for (r = 0; r < conv_pkg::KERNEL_HEIGHT; r++) begin
                for (c = 0; c < conv_pkg::KERNEL_WIDTH; c++) begin
                    pix  = window[o + r][c];
                    wgt  = rom_image[r * conv_pkg::KERNEL_WIDTH + c];
                    prod = longint'(pix) * longint'(wgt);
                    acc  = acc + (prod >>> conv_pkg::FRAC_BITS);
                end
            end
            acc = acc + longint'(rom_image[conv_pkg::NUM_TAPS]);
            result[o] = acc[conv_pkg::WORD_SIZE-1:0];
        end
        return result;
    endfunction

    // age counts edges after the accepted start and sampled values lag by one edge
    always @(posedge clk_i) begin
        int o;
        if (reset_i) begin
            busy = 1'b0;
            age  = 0;
            held = '0;
        end else begin
            if (busy) begin
                age = age + 1;
                if (age == 1)
                    expected = conv_ref(data_i);
                if (age < conv_pkg::NUM_TAPS + 3) begin
                    if (done_i) begin
                        $display("done_o high %0d cycles after start, at %0t ns", age - 1, $time);
                        timing_errors_o++;
                    end
                end else begin
                    if (!done_i) begin
                        $display("done_o still low %0d cycles after start, at %0t ns",
                                 age - 1, $time);
                        timing_errors_o++;
                    end
                    for (o = 0; o < conv_pkg::NUM_OUTPUTS; o++) begin
                        if (data_out_i[o] !== expected[o]) begin
                            $display("Mismatch at %0t ns: output %0d is %h, expected %h",
                                     $time, o, data_out_i[o], expected[o]);
                            value_errors_o++;
                        end
                    end
                    held = expected;
                    busy = 1'b0;
                    results_o++;
                end
            end else begin
                if (!done_i) begin
                    $display("done_o low with no accepted start, at %0t ns", $time);
                    timing_errors_o++;
                end
                if (data_out_i !== held) begin
                    $display("Mismatch at %0t ns: data_o changed while idle, %h instead of %h",
                             $time, data_out_i, held);
                    value_errors_o++;
                end
            end
            // a start is only taken while the layer is idle
            if (!busy && done_i && start_i) begin
                busy = 1'b1;
                age  = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/conv_layer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conv_layer_tb;

    logic                clk_i;
    logic                reset_i;
    logic                start_i;
    conv_pkg::data_in_t  data_i;
    logic                done_o;
    conv_pkg::data_out_t data_o;
    int                  value_errors;
    int                  timing_errors;
    int                  results;
    int                  timeout_errors;
    int                  runs;

    conv_layer i_dut (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (start_i),
        .data_i  (data_i),
        .done_o  (done_o),
        .data_o  (data_o)
    );

    conv_layer_checker u_checker (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .start_i         (start_i),
        .data_i          (data_i),
        .done_i          (done_o),
        .data_out_i      (data_o),
        .value_errors_o  (value_errors),
        .timing_errors_o (timing_errors),
        .results_o       (results)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // mostly small values with full range now and then to force wrap-around
    function automatic conv_pkg::word_t random_word();
        if ($urandom_range(3) == 0)
            return conv_pkg::word_t'($urandom);
        return conv_pkg::word_t'($urandom_range(1023) - 512);
    endfunction

    function automatic conv_pkg::data_in_t random_window();
        conv_pkg::data_in_t window;
        int                 r;
        int                 c;
        for (r = 0; r < conv_pkg::INPUT_HEIGHT; r++)
            for (c = 0; c < conv_pkg::KERNEL_WIDTH; c++)
                window[r][c] = random_word();
        return window;
    endfunction

    task automatic wait_done();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!done_o && cycles < 40);
        if (!done_o) begin
            $display("Timeout: done_o did not rise within 40 cycles, at %0t ns", $time);
            timeout_errors++;
        end
    endtask

    // one start pulse and optionally a second one while busy
    task automatic single_run(input logic busy_pulse);
        @(posedge clk_i);
        data_i  <= random_window();
        start_i <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        if (busy_pulse) begin
            repeat (3) @(posedge clk_i);
            start_i <= 1'b1;
            @(posedge clk_i);
            start_i <= 1'b0;
        end
        wait_done();
        runs++;
    endtask

    // with start held high every completion starts the next run at once
    task automatic held_runs(input int count);
        int n;
        @(posedge clk_i);
        data_i  <= random_window();
        start_i <= 1'b1;
        @(posedge clk_i);
        for (n = 0; n < count; n++) begin
            wait_done();
            data_i <= random_window();
            runs++;
        end
        start_i <= 1'b0;
        wait_done();
        runs++;
    endtask

    initial begin
        int n;
        void'($urandom(32'he0ab9180));
        reset_i        = 1'b1;
        start_i        = 1'b0;
        data_i         = '0;
        timeout_errors = 0;
        runs           = 0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        for (n = 0; n < 160 && timeout_errors == 0; n++)
            single_run(n % 8 == 7);
        for (n = 0; n < 2 && timeout_errors == 0; n++) begin
            held_runs(20);
            repeat (3) @(posedge clk_i);
        end
        repeat (5) @(posedge clk_i);
        if (results != runs)
            $display("only %0d of %0d runs produced a checked result", results, runs);
        $display("errors: value %0d, timing %0d, timeout %0d; runs %0d, results %0d",
                 value_errors, timing_errors, timeout_errors, runs, results);
        if (value_errors + timing_errors + timeout_errors == 0 && results == runs)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
